//--- testbench/cpu_patterns.txt
// instruction word, expected rd (00 when nothing commits), expected rd value
// one instruction per line in program order
06400093 01 00000064  // addi x1, x0, 100
FFB00113 02 FFFFFFFB  // addi x2, x0, -5
002081B3 03 0000005F  // add  x3, x1, x2
40208233 04 00000069  // sub  x4, x1, x2
0020F2B3 05 00000060  // and  x5, x1, x2
0020E333 06 FFFFFFFF  // or   x6, x1, x2
0020C3B3 07 FFFFFF9F  // xor  x7, x1, x2
02730433 08 00000061  // mul  x8, x6, x7
00108493 09 00000065  // addi x9, x1, 1
0041C533 0A 00000036  // xor  x10, x3, x4
02210633 0C 00000019  // mul  x12, x2, x2
001405B3 0B 000000C5  // add  x11, x8, x1
7FF00693 0D 000007FF  // addi x13, x0, 2047
0000A703 00 00000000  // lw   x14, 0(x1), not supported
401686B3 0D 0000079B  // sub  x13, x13, x1
00560613 0C 0000001E  // addi x12, x12, 5
02768733 0E FFFD1E45  // mul  x14, x13, x7
80000793 0F FFFFF800  // addi x15, x0, -2048
00108033 00 00000000  // add  x0, x1, x1
0097E833 10 FFFFF865  // or   x16, x15, x9
02E708B3 11 4DF63E99  // mul  x17, x14, x14
0108F933 12 4DF63801  // and  x18, x17, x16
40A489B3 13 0000002F  // sub  x19, x9, x10
0010C0B3 01 00000000  // xor  x1, x1, x1

//--- alioth_core.f
rtl/alioth_pkg.sv
rtl/inst_queue.sv
rtl/idu.sv
rtl/hdu.sv
rtl/exu_muldiv.sv
rtl/exu.sv
rtl/wbu.sv
rtl/gpr.sv
rtl/cpu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_cpu_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the alioth core testbench with verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_cpu_top \
    -f alioth_core.f --Mdir obj_dir -o Vtb_cpu_top > build.log 2>&1 \
    && ./obj_dir/Vtb_cpu_top > sim.log 2>&1 \
    || { cat build.log; echo "simulation could not be built or run"; }
[ -f sim.log ] && cat sim.log
grep -qx "TEST RESULT: PASS" sim.log 2>/dev/null && exit 0 || exit 1

//--- testbench/tb_cpu_top.sv
// testbench for the alioth execution core
// streams instructions from a pattern file under credit flow control,
// checks each commit against a per-register queue of expected values

`default_nettype none

module tb_cpu_top import alioth_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_PAT          = 24;
    localparam int          QUIET_CYCLES   = 7;  // reset plus a few idle cycles
    localparam int          TIMEOUT_CYCLES = N_PAT * (MUL_CYCLES + 4) + 100;
    localparam logic [31:0] LFSR_SEED      = 32'hf86e8a07;

    logic              clk;
    logic              rst_n;
    logic              inst_valid;
    logic [INST_W-1:0] inst;
    logic              credit;
    wb_req_t           commit;

    logic [31:0] pat_mem [3*N_PAT];  // word, rd, value per pattern
    logic [31:0] model_regs [32];
    logic [31:0] exp_q [32][$];
    int          seq_q [32][$];      // program index of each expected commit
    logic [31:0] lfsr_q;
    int          credits;
    int          sent;
    int          credit_pulses;
    int          pending;
    int          commits;
    int          last_seq;
    int          overtakes;
    int          errors;
    int          tests;
    int          failed_tests;

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    cpu_top i_cpu_top (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .credit_o     (credit),
        .commit_o     (commit)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b      = lfsr_q[0];
    endtask

    // architectural model of the supported subset, in program order
    task automatic model_exec(input logic [31:0] word, output logic [4:0] rd,
                              output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        ok;
        a   = model_regs[word[19:15]];
        b   = model_regs[word[24:20]];
        imm = {{20{word[31]}}, word[31:20]};
        ok  = 1'b1;
        val = '0;
        if (word[6:0] == 7'h13 && word[14:12] == 3'h0) begin
            val = a + imm;  // addi
        end else if (word[6:0] == 7'h33) begin
            case ({word[31:25], word[14:12]})
                {7'h00, 3'h0}: val = a + b;
                {7'h20, 3'h0}: val = a - b;
                {7'h00, 3'h7}: val = a & b;
                {7'h00, 3'h6}: val = a | b;
                {7'h00, 3'h4}: val = a ^ b;
                {7'h01, 3'h0}: val = a * b;  // low half only
                default:       ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        rd = ok ? word[11:7] : 5'd0;
        if (rd != 5'd0)
            model_regs[rd] = val;
        else
            val = '0;
    endtask

    // credit and commit sampling, once per cycle while outputs are stable
    task automatic observe_cycle();
        logic [31:0] exp_val;
        int          seq;
        if (credit) begin
            credits++;
            credit_pulses++;
            assert (credits <= QUEUE_DEPTH) else begin
                $display("%0t: credit_o returned a credit beyond the queue depth", $time);
                errors++;
            end
        end
        if (commit.valid) begin
            commits++;
            assert (exp_q[commit.rd].size() > 0) else begin
                $display("%0t: commit to x%0d with no commit expected there", $time, commit.rd);
                errors++;
            end
            if (exp_q[commit.rd].size() > 0) begin
                exp_val = exp_q[commit.rd].pop_front();
                seq     = seq_q[commit.rd].pop_front();
                pending--;
                if (seq < last_seq)
                    overtakes++;  // a younger instruction already committed
                else
                    last_seq = seq;
                assert (commit.data == exp_val) else begin
                    $display("Mismatch at %0t: commit_o.data (x%0d) expected %h got %h",
                             $time, commit.rd, exp_val, commit.data);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int base);
        tests++;
        if (errors != base)
            failed_tests++;
        $display("test %s: %s, %0d errors", name, (errors == base) ? "ok" : "failed",
                 errors - base);
    endtask

    initial begin
        int          idx;
        int          base;
        logic        gap_a;
        logic        gap_b;
        logic [4:0]  m_rd;
        logic [31:0] m_val;
        inst_valid    = 1'b0;
        inst          = '0;
        lfsr_q        = LFSR_SEED;
        credits       = QUEUE_DEPTH;
        sent          = 0;
        credit_pulses = 0;
        pending       = 0;
        commits       = 0;
        last_seq      = -1;
        overtakes     = 0;
        errors        = 0;
        tests         = 0;
        failed_tests  = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        $readmemh("testbench/cpu_patterns.txt", pat_mem);

        base = errors;
        for (int i = 0; i < N_PAT; i++) begin
            model_exec(pat_mem[3*i], m_rd, m_val);
            assert (m_rd == pat_mem[3*i+1][4:0] && m_val == pat_mem[3*i+2]) else begin
                $display("pattern %0d: file expects x%0d = %h, model gives x%0d = %h",
                         i, pat_mem[3*i+1][4:0], pat_mem[3*i+2], m_rd, m_val);
                errors++;
            end
        end
        report_test("pattern_model", base);

        base = errors;
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            #1;
            assert (!commit.valid) else begin
                $display("Mismatch at %0t: commit_o.valid expected 0 got %b", $time, commit.valid);
                errors++;
            end
            assert (!credit) else begin
                $display("Mismatch at %0t: credit_o expected 0 got %b", $time, credit);
                errors++;
            end
        end
        report_test("reset_quiet", base);

        base = errors;
        idx  = 0;
        while (idx < N_PAT) begin
            @(posedge clk);
            #1;
            observe_cycle();
            take_bit(gap_a);
            take_bit(gap_b);
            if (credits > 0 && !(gap_a && gap_b)) begin  // idle about one cycle in four
                inst_valid = 1'b1;
                inst       = pat_mem[3*idx];
                credits--;
                sent++;
                if (pat_mem[3*idx+1] != 0) begin
                    exp_q[pat_mem[3*idx+1][4:0]].push_back(pat_mem[3*idx+2]);
                    seq_q[pat_mem[3*idx+1][4:0]].push_back(idx);
                    pending++;
                end
                idx++;
            end else begin
                inst_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        observe_cycle();
        while (credits != QUEUE_DEPTH) begin  // every word has left the queue
            @(posedge clk);
            #1;
            observe_cycle();
        end
        repeat (MUL_CYCLES + 4) begin  // last multiply commits within this window
            @(posedge clk);
            #1;
            observe_cycle();
        end
        report_test("commit_stream", base);

        base = errors;
        for (int r = 0; r < 32; r++) begin
            assert (exp_q[r].size() == 0) else begin
                $display("x%0d still waits for %0d commits", r, exp_q[r].size());
                errors++;
            end
        end
        report_test("queues_empty", base);

        base = errors;
        assert (overtakes > 0) else begin
            $display("no ALU result committed ahead of an earlier multiply");
            errors++;
        end
        report_test("mul_overlap", base);

        base = errors;
        assert (credit_pulses == sent) else begin
            $display("Mismatch at %0t: credit_o pulses expected %0d got %0d",
                     $time, sent, credit_pulses);
            errors++;
        end
        assert (credits == QUEUE_DEPTH) else begin
            $display("sender holds %0d credits at the end instead of %0d", credits, QUEUE_DEPTH);
            errors++;
        end
        report_test("credit_return", base);

        $display("%0d tests, %0d failed, %0d errors, %0d commits checked",
                 tests, failed_tests, errors, commits);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d commits still outstanding",
                 TIMEOUT_CYCLES, pending);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// clock and reset source for the core testbench
// 10 ns clock, reset held low for the first 4 cycles

`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;  // release just after the edge
    end

endmodule

`default_nettype wire

//--- rtl/cpu_top.sv
// alioth execution core top
// credit-based issue port, decode, hazard check, ALU and multiply,
// writeback to the register file and the commit port

`default_nettype none

module cpu_top import alioth_pkg::*; (
    input  wire               clk,
    input  wire               rst_n_i,
    input  logic              inst_valid_i,
    input  logic [INST_W-1:0] inst_i,
    output logic              credit_o,
    output wb_req_t           commit_o
);

    logic                  head_valid;
    logic [INST_W-1:0]     head_inst;
    logic                  pop;
    logic                  stall;
    logic                  issue;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    dec_op_t               dec;
    wb_req_t               alu_wb;
    wb_req_t               mul_wb;
    wb_req_t               wb;
    logic                  mul_done;
    logic                  alu_ready;

    assign issue    = pop & dec.valid;  // unsupported words are popped silently
    assign commit_o = wb;

    inst_queue u_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .credit_o     (credit_o)
    );

    idu u_idu (
        .head_valid_i (head_valid),
        .head_inst_i  (head_inst),
        .stall_i      (stall),
        .rs1_rdata_i  (rs1_rdata),
        .rs2_rdata_i  (rs2_rdata),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .dec_o        (dec),
        .pop_o        (pop)
    );

    hdu u_hdu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_i       (dec),
        .issue_i     (issue),
        .mul_done_i  (mul_done),
        .alu_ready_i (alu_ready),
        .stall_o     (stall)
    );

    exu u_exu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_i       (dec),
        .issue_i     (issue),
        .alu_ready_i (alu_ready),
        .alu_wb_o    (alu_wb),
        .mul_wb_o    (mul_wb),
        .mul_done_o  (mul_done)
    );

    wbu u_wbu (
        .alu_wb_i    (alu_wb),
        .mul_wb_i    (mul_wb),
        .alu_ready_o (alu_ready),
        .wb_o        (wb)
    );

    gpr u_gpr (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_rdata),
        .rdata2_o (rs2_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/gpr.sv
// general purpose register file
// 32 x 32, two read ports with write bypass, x0 reads zero

`default_nettype none

module gpr import alioth_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wb_req_t               wb_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs_q [2**REG_ADDR_W];
    logic            we;

    assign we = wb_i.valid && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs_q[i] <= '0;
        end else if (we) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        if (raddr1_i == '0)
            rdata1_o = '0;
        else if (we && wb_i.rd == raddr1_i)
            rdata1_o = wb_i.data;  // same-cycle write
        else
            rdata1_o = regs_q[raddr1_i];

        if (raddr2_i == '0)
            rdata2_o = '0;
        else if (we && wb_i.rd == raddr2_i)
            rdata2_o = wb_i.data;
        else
            rdata2_o = regs_q[raddr2_i];
    end

endmodule

`default_nettype wire

//--- rtl/wbu.sv
// writeback unit
// fixed-priority merge of multiply and ALU results into one write port,
// which is also the commit port

`default_nettype none

module wbu import alioth_pkg::*; (
    input  wb_req_t alu_wb_i,
    input  wb_req_t mul_wb_i,
    output logic    alu_ready_o,
    output wb_req_t wb_o
);

    wb_req_t sel;

    // multiply pulses for one cycle only and cannot wait
    assign alu_ready_o = ~mul_wb_i.valid;
    assign sel         = mul_wb_i.valid ? mul_wb_i : alu_wb_i;

    always_comb begin
        wb_o = sel;
        if (sel.rd == '0)
            wb_o.valid = 1'b0;  // x0 writes are dropped
    end

endmodule

`default_nettype wire

//--- rtl/exu.sv
// execution unit
// one-cycle ALU with a result register held under back-pressure,
// multiplies handed to the iterative unit

`default_nettype none

module exu import alioth_pkg::*; (
    input  wire     clk,
    input  wire     rst_n_i,
    input  dec_op_t dec_i,
    input  logic    issue_i,
    input  logic    alu_ready_i,
    output wb_req_t alu_wb_o,
    output wb_req_t mul_wb_o,
    output logic    mul_done_o
);

    logic                  alu_issue;
    logic [XLEN-1:0]       alu_res;
    logic                  alu_vld_q;
    logic [REG_ADDR_W-1:0] alu_rd_q;
    logic [XLEN-1:0]       alu_data_q;

    assign alu_issue = issue_i & ~dec_i.is_mul & dec_i.rd_we;

    always_comb begin
        case (dec_i.alu_op)
            ALU_SUB: alu_res = dec_i.operand_a - dec_i.operand_b;
            ALU_AND: alu_res = dec_i.operand_a & dec_i.operand_b;
            ALU_OR:  alu_res = dec_i.operand_a | dec_i.operand_b;
            ALU_XOR: alu_res = dec_i.operand_a ^ dec_i.operand_b;
            default: alu_res = dec_i.operand_a + dec_i.operand_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            alu_vld_q <= 1'b0;
        else if (alu_issue)
            alu_vld_q <= 1'b1;
        else if (alu_ready_i)
            alu_vld_q <= 1'b0;  // accepted by wbu
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_rd_q   <= dec_i.rd;
            alu_data_q <= alu_res;
        end
    end

    assign alu_wb_o = '{valid: alu_vld_q, rd: alu_rd_q, data: alu_data_q};

    exu_muldiv u_exu_muldiv (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (issue_i & dec_i.is_mul),
        .rd_i    (dec_i.rd),
        .a_i     (dec_i.operand_a),
        .b_i     (dec_i.operand_b),
        .done_o  (mul_done_o),
        .wb_o    (mul_wb_o)
    );

endmodule

`default_nettype wire

//--- rtl/exu_muldiv.sv
// iterative multiplier
// shift-add over MUL_CYCLES steps, keeps the low XLEN bits of the product

`default_nettype none

module exu_muldiv import alioth_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  logic                  start_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       a_i,
    input  logic [XLEN-1:0]       b_i,
    output logic                  done_o,
    output wb_req_t               wb_o
);

    logic                          busy_q;
    logic                          done_q;
    logic [$clog2(MUL_CYCLES)-1:0] cnt_q;
    logic [REG_ADDR_W-1:0]         rd_q;
    logic [XLEN-1:0]               mcand_q;  // shifted left each step
    logic [XLEN-1:0]               mplier_q; // shifted right each step
    logic [XLEN-1:0]               acc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == $clog2(MUL_CYCLES)'(MUL_CYCLES - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;  // last step lands with the pulse
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rd_q     <= rd_i;
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if (busy_q) begin
            if (mplier_q[0])
                acc_q <= acc_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign done_o = done_q;
    assign wb_o   = '{valid: done_q, rd: rd_q, data: acc_q};

endmodule

`default_nettype wire

//--- rtl/hdu.sv
// hazard detection unit
// tracks the one multiply in flight and stalls issue on RAW, WAW,
// a second multiply, or a held ALU result

`default_nettype none

module hdu import alioth_pkg::*; (
    input  wire     clk,
    input  wire     rst_n_i,
    input  dec_op_t dec_i,
    input  logic    issue_i,
    input  logic    mul_done_i,
    input  logic    alu_ready_i,
    output logic    stall_o
);

    logic                  busy_q;
    logic [REG_ADDR_W-1:0] mul_rd_q;
    logic                  raw;
    logic                  waw;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            mul_rd_q <= '0;
        end else if (issue_i && dec_i.is_mul) begin
            busy_q   <= 1'b1;
            mul_rd_q <= dec_i.rd;
        end else if (mul_done_i) begin
            busy_q <= 1'b0;  // result is in gpr from the next cycle
        end
    end

    // x0 as multiply target never blocks anything
    assign raw = (mul_rd_q != '0) && (dec_i.rs1 == mul_rd_q || dec_i.rs2 == mul_rd_q);
    assign waw = dec_i.rd_we && (dec_i.rd == mul_rd_q);

    assign stall_o = dec_i.valid & ((busy_q & (dec_i.is_mul | raw | waw)) | ~alu_ready_i);

endmodule

`default_nettype wire

//--- rtl/idu.sv
// instruction decode unit
// turns the queue head into an operation record with register operands;
// unsupported encodings decode as invalid and are simply popped

`default_nettype none

module idu import alioth_pkg::*; (
    input  logic                  head_valid_i,
    input  logic [INST_W-1:0]     head_inst_i,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       rs1_rdata_i,
    input  logic [XLEN-1:0]       rs2_rdata_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output dec_op_t               dec_o,
    output logic                  pop_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic            supported;
    logic            is_imm;
    logic            is_mul;
    alu_op_e         alu_op;

    assign opcode = head_inst_i[6:0];
    assign funct3 = head_inst_i[14:12];
    assign funct7 = head_inst_i[31:25];
    assign imm_i  = {{(XLEN-12){head_inst_i[31]}}, head_inst_i[31:20]};

    always_comb begin
        supported = 1'b0;
        is_imm    = 1'b0;
        is_mul    = 1'b0;
        alu_op    = ALU_ADD;
        if (opcode == OPC_OP) begin
            supported = 1'b1;
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: alu_op = ALU_ADD;
                {7'b0000000, 3'b100}: alu_op = ALU_XOR;
                {7'b0000000, 3'b110}: alu_op = ALU_OR;
                {7'b0000000, 3'b111}: alu_op = ALU_AND;
                {7'b0100000, 3'b000}: alu_op = ALU_SUB;
                {7'b0000001, 3'b000}: is_mul = 1'b1;
                default:              supported = 1'b0;
            endcase
        end else if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin  // addi
            supported = 1'b1;
            is_imm    = 1'b1;
        end
    end

    assign rs1_addr_o = head_inst_i[19:15];
    assign rs2_addr_o = is_imm ? '0 : head_inst_i[24:20];  // imm bits are no register

    assign dec_o.valid     = head_valid_i & supported;
    assign dec_o.is_mul    = is_mul;
    assign dec_o.alu_op    = alu_op;
    assign dec_o.rd        = head_inst_i[11:7];
    assign dec_o.rs1       = rs1_addr_o;
    assign dec_o.rs2       = rs2_addr_o;
    assign dec_o.rd_we     = supported & (head_inst_i[11:7] != '0);  // x0 is never written
    assign dec_o.operand_a = rs1_rdata_i;
    assign dec_o.operand_b = is_imm ? imm_i : rs2_rdata_i;

    assign pop_o = head_valid_i & ~stall_i;

endmodule

`default_nettype wire

//--- rtl/inst_queue.sv
// issue buffer
// circular FIFO that takes instructions under credit flow control
// and returns one credit for every entry that leaves

`default_nettype none

module inst_queue import alioth_pkg::*; (
    input  wire               clk,
    input  wire               rst_n_i,
    input  logic              inst_valid_i,
    input  logic [INST_W-1:0] inst_i,
    input  logic              pop_i,
    output logic              head_valid_o,
    output logic [INST_W-1:0] head_inst_o,
    output logic              credit_o
);

    logic [INST_W-1:0]              mem_q [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0] wptr_q;
    logic [$clog2(QUEUE_DEPTH)-1:0] rptr_q;
    logic [CREDIT_W-1:0]            count_q;
    logic                           do_pop;

    assign head_valid_o = (count_q != '0);
    assign head_inst_o  = mem_q[rptr_q];
    assign do_pop       = pop_i & head_valid_o;

    // sender holds a credit for every push, so no full check here
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr_q   <= '0;
            rptr_q   <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (inst_valid_i)
                wptr_q <= wptr_q + 1'b1;
            if (do_pop)
                rptr_q <= rptr_q + 1'b1;
            count_q  <= count_q + CREDIT_W'(inst_valid_i) - CREDIT_W'(do_pop);
            credit_o <= do_pop;  // credit back one cycle after the pop
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i)
            mem_q[wptr_q] <= inst_i;
    end

endmodule

`default_nettype wire

//--- rtl/alioth_pkg.sv
// alioth core shared definitions
// widths, opcodes, decoded operation record and writeback record

`default_nettype none

package alioth_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int INST_W      = 32;
    localparam int QUEUE_DEPTH = 4;   // also the sender's credits after reset
    localparam int CREDIT_W    = 3;
    localparam int MUL_CYCLES  = 32;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic                  valid;    // supported instruction at queue head
        logic                  is_mul;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rd_we;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
    } dec_op_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_req_t;

endpackage

`default_nettype wire
